/* flist.f */
src/soc_bus_pkg.sv
src/axi_lite_arbiter.sv
src/axi_lite_xbar.sv
src/axi_lite_sram.sv
src/axi_lite_console.sv
src/axi_lite_clint.sv
src/soc_bus_top.sv
testbench/tb_soc_bus.sv

/* Bender.yml */
package:
  name: soc_bus

sources:
  - src/soc_bus_pkg.sv
  - src/axi_lite_arbiter.sv
  - src/axi_lite_xbar.sv
  - src/axi_lite_sram.sv
  - src/axi_lite_console.sv
  - src/axi_lite_clint.sv
  - src/soc_bus_top.sv
  - target: test
    files:
      - testbench/tb_soc_bus.sv

/* testbench/tb_soc_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus
    import soc_bus_pkg::*;
;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 10;
    // Cycle budget per bus transaction and a bound on their number
    localparam int txn_budget      = 20;
    localparam int max_txns        = 100;
    localparam int watchdog_cycles = reset_cycles + max_txns * txn_budget;

    logic           clk;
    logic           reset;
    axi_lite_req_t  m_req [2];
    axi_lite_resp_t m_resp [2];
    logic [7:0]     tx_data;
    logic           tx_valid;

    logic [31:0]       rng_state;
    logic [data_w-1:0] scoreboard [sram_words];
    logic [7:0]        tx_seen [$];
    time               done_time [2];
    int                error_count;
    int                check_count;
    int                tests_run;
    int                tests_bad;

    soc_bus_top dut_i (
        .clk      (clk),
        .reset    (reset),
        .m0_req   (m_req[0]),
        .m1_req   (m_req[1]),
        .m0_resp  (m_resp[0]),
        .m1_resp  (m_resp[1]),
        .tx_data  (tx_data),
        .tx_valid (tx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a bus transaction never finished",
                 watchdog_cycles);
        $display("tests failed");
        $finish;
    end

    // Console byte stream sampled mid-cycle
    always @(negedge clk) begin
        if (reset === 1'b0 && tx_valid === 1'b1) begin
            tx_seen.push_back(tx_data);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_data(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input logic [resp_w-1:0] got,
                              input logic [resp_w-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic expect_true(input string what, input logic cond);
        check_count++;
        if (cond !== 1'b1) begin
            error_count++;
            $display("Check failed at %0t ns: %s", $time, what);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // Handshakes are sampled at the falling edge where DUT outputs have settled
    task automatic axi_write(input int master, input logic [addr_w-1:0] addr,
                             input logic [data_w-1:0] data, input logic [strb_w-1:0] strb,
                             output logic [resp_w-1:0] resp);
        @(posedge clk);
        #1;
        m_req[master].awaddr  = addr;
        m_req[master].wdata   = data;
        m_req[master].wstrb   = strb;
        m_req[master].awvalid = 1'b1;
        m_req[master].wvalid  = 1'b1;
        @(negedge clk);
        while (!(m_resp[master].awready && m_resp[master].wready)) @(negedge clk);
        @(posedge clk);
        #1;
        m_req[master].awvalid = 1'b0;
        m_req[master].wvalid  = 1'b0;
        m_req[master].bready  = 1'b1;
        @(negedge clk);
        while (!m_resp[master].bvalid) @(negedge clk);
        resp = m_resp[master].bresp;
        @(posedge clk);
        done_time[master] = $time;
        #1;
        m_req[master].bready = 1'b0;
    endtask

    // hold_cycles keeps rready low that long after rvalid rises
    task automatic axi_read(input int master, input logic [addr_w-1:0] addr,
                            input int hold_cycles, output logic [data_w-1:0] data,
                            output logic [resp_w-1:0] resp);
        @(posedge clk);
        #1;
        m_req[master].araddr  = addr;
        m_req[master].arvalid = 1'b1;
        m_req[master].rready  = (hold_cycles == 0);
        @(negedge clk);
        while (!m_resp[master].arready) @(negedge clk);
        @(posedge clk);
        #1;
        m_req[master].arvalid = 1'b0;
        @(negedge clk);
        while (!m_resp[master].rvalid) @(negedge clk);
        data = m_resp[master].rdata;
        resp = m_resp[master].rresp;
        if (hold_cycles > 0) begin
            repeat (hold_cycles) begin
                @(negedge clk);
                check_flag("rvalid under back-pressure", m_resp[master].rvalid, 1'b1);
                check_data("rdata under back-pressure", m_resp[master].rdata, data);
            end
            @(posedge clk);
            #1;
            m_req[master].rready = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        done_time[master] = $time;
        #1;
        m_req[master].rready = 1'b0;
    endtask

    task automatic test_sram_round_trip();
        int                err0;
        logic [addr_w-1:0] addrs [16];
        logic [data_w-1:0] wd;
        logic [data_w-1:0] rd;
        logic [resp_w-1:0] rs;
        err0 = error_count;
        for (int i = 0; i < 16; i++) begin
            addrs[i] = next_random() & 32'h0000_0ffc;
            wd = next_random();
            axi_write(i % 2, addrs[i], wd, 4'hf, rs);
            check_resp("bresp", rs, resp_okay);
            scoreboard[addrs[i][11:2]] = wd;
        end
        for (int i = 0; i < 16; i++) begin
            axi_read(i % 2, addrs[i], 0, rd, rs);
            check_resp("rresp", rs, resp_okay);
            check_data("sram rdata", rd, scoreboard[addrs[i][11:2]]);
        end
        report_test("sram round trip", err0);
    endtask

    task automatic test_strobes_alias();
        int                err0;
        logic [addr_w-1:0] base;
        logic [data_w-1:0] wd;
        logic [data_w-1:0] rd;
        logic [resp_w-1:0] rs;
        err0 = error_count;
        base = next_random() & 32'h0000_0ffc;
        axi_write(0, base, 32'h1122_3344, 4'hf, rs);
        check_resp("bresp", rs, resp_okay);
        axi_write(1, base, 32'haabb_ccdd, 4'b0101, rs);
        axi_write(0, base, 32'h5500_0000, 4'b1000, rs);
        axi_read(1, base, 0, rd, rs);
        // Byte 3 from the last write, bytes 2 and 0 from the second, byte 1 from the first
        check_data("merged word", rd, 32'h55bb_33dd);
        // Address bits above 11 are ignored by the SRAM
        wd = next_random();
        axi_write(0, base + 32'd4096, wd, 4'hf, rs);
        axi_read(0, base, 0, rd, rs);
        check_resp("rresp", rs, resp_okay);
        check_data("aliased word", rd, wd);
        report_test("byte strobes and aliasing", err0);
    endtask

    task automatic test_console();
        int                err0;
        logic [7:0]        bytes [3];
        logic [data_w-1:0] shadow;
        logic [data_w-1:0] rd;
        logic [resp_w-1:0] rs;
        err0 = error_count;
        // SRAM word at the same index as the console address
        shadow = next_random();
        axi_write(1, 32'h0000_03f8, shadow, 4'hf, rs);
        tx_seen.delete();
        for (int i = 0; i < 3; i++) begin
            bytes[i] = 8'(next_random());
            axi_write(i % 2, uart_thr_addr, {24'h0, bytes[i]}, 4'b0001, rs);
            check_resp("console bresp", rs, resp_okay);
        end
        expect_true("console emitted exactly three bytes", tx_seen.size() == 3);
        for (int i = 0; i < 3 && i < tx_seen.size(); i++) begin
            check_byte("tx_data", tx_seen[i], bytes[i]);
        end
        axi_read(0, uart_thr_addr, 0, rd, rs);
        check_data("console byte count", rd, 32'd3);
        axi_read(1, 32'h0000_03f8, 0, rd, rs);
        check_data("sram word behind console", rd, shadow);
        report_test("console path", err0);
    endtask

    task automatic test_timer();
        int                err0;
        logic [data_w-1:0] t0;
        logic [data_w-1:0] t1;
        logic [resp_w-1:0] rs;
        err0 = error_count;
        axi_read(0, 32'ha000_0048, 0, t0, rs);
        axi_read(1, 32'ha000_0048, 0, t1, rs);
        check_resp("timer rresp", rs, resp_okay);
        expect_true("second mtime read is larger than the first", t1 > t0);
        axi_write(0, 32'ha000_0048, 32'h1000_0000, 4'hf, rs);
        check_resp("timer bresp", rs, resp_okay);
        axi_read(1, 32'ha000_0048, 0, t1, rs);
        expect_true("mtime continues from the loaded value",
                    t1 >= 32'h1000_0000 && t1 < 32'h1000_0000 + 50);
        axi_read(0, 32'ha000_0048, 0, t0, rs);
        axi_read(0, 32'ha000_004b, 0, t1, rs);
        expect_true("unaligned timer address still reads mtime", t1 > t0 && t1 - t0 < 50);
        report_test("timer", err0);
    endtask

    task automatic test_contention();
        int                err0;
        logic [addr_w-1:0] a0;
        logic [addr_w-1:0] a1;
        logic [data_w-1:0] d0;
        logic [data_w-1:0] d1;
        logic [data_w-1:0] r0;
        logic [data_w-1:0] r1;
        logic [resp_w-1:0] s0;
        logic [resp_w-1:0] s1;
        err0 = error_count;
        a0 = next_random() & 32'h0000_0ffc;
        a1 = a0 ^ 32'h4;
        d0 = next_random();
        d1 = next_random();
        fork
            axi_write(0, a0, d0, 4'hf, s0);
            axi_write(1, a1, d1, 4'hf, s1);
        join
        check_resp("m0 bresp", s0, resp_okay);
        check_resp("m1 bresp", s1, resp_okay);
        fork
            axi_read(0, a0, 0, r0, s0);
            axi_read(1, a1, 0, r1, s1);
        join
        check_data("m0 rdata", r0, d0);
        check_data("m1 rdata", r1, d1);
        // m0 holds the bus under back-pressure while m1 waits
        fork
            axi_read(0, a0, 5, r0, s0);
            begin
                @(posedge clk);
                axi_read(1, a1, 0, r1, s1);
            end
        join
        check_data("m0 rdata after stall", r0, d0);
        check_data("m1 rdata after stall", r1, d1);
        expect_true("m1 read finished after the stalled m0 read", done_time[1] > done_time[0]);
        report_test("contention", err0);
    endtask

    initial begin
        rng_state   = 32'h6bb4_21be;
        error_count = 0;
        check_count = 0;
        tests_run   = 0;
        tests_bad   = 0;
        m_req[0]    = '0;
        m_req[1]    = '0;
        reset       = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        test_sram_round_trip();
        test_strobes_alias();
        test_console();
        test_timer();
        test_contention();

        $display("Summary: %0d run, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/soc_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top
    import soc_bus_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire axi_lite_req_t m0_req,
    input  wire axi_lite_req_t m1_req,
    output axi_lite_resp_t     m0_resp,
    output axi_lite_resp_t     m1_resp,
    output logic [7:0]         tx_data,
    output logic               tx_valid
);

    axi_lite_req_t  bus_req;
    axi_lite_resp_t bus_resp;
    axi_lite_req_t  sram_req;
    axi_lite_resp_t sram_resp;
    axi_lite_req_t  console_req;
    axi_lite_resp_t console_resp;
    axi_lite_req_t  clint_req;
    axi_lite_resp_t clint_resp;

    axi_lite_arbiter arbiter_i (
        .clk      (clk),
        .reset    (reset),
        .m0_req   (m0_req),
        .m1_req   (m1_req),
        .m0_resp  (m0_resp),
        .m1_resp  (m1_resp),
        .bus_req  (bus_req),
        .bus_resp (bus_resp)
    );

    axi_lite_xbar xbar_i (
        .clk          (clk),
        .reset        (reset),
        .bus_req      (bus_req),
        .bus_resp     (bus_resp),
        .sram_req     (sram_req),
        .console_req  (console_req),
        .clint_req    (clint_req),
        .sram_resp    (sram_resp),
        .console_resp (console_resp),
        .clint_resp   (clint_resp)
    );

    axi_lite_sram sram_i (
        .clk   (clk),
        .reset (reset),
        .req   (sram_req),
        .resp  (sram_resp)
    );

    axi_lite_console console_i (
        .clk      (clk),
        .reset    (reset),
        .req      (console_req),
        .resp     (console_resp),
        .tx_data  (tx_data),
        .tx_valid (tx_valid)
    );

    axi_lite_clint clint_i (
        .clk   (clk),
        .reset (reset),
        .req   (clint_req),
        .resp  (clint_resp)
    );

endmodule

`default_nettype wire

/* src/axi_lite_clint.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_clint
    import soc_bus_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire axi_lite_req_t req,
    output axi_lite_resp_t     resp
);

    logic [data_w-1:0] mtime_q;
    logic [data_w-1:0] mtime_d;
    logic [data_w-1:0] rdata_q;
    logic              rvalid_q;
    logic              bvalid_q;
    logic              idle;
    logic              ar_hs;
    logic              wr_hs;

    assign idle  = !rvalid_q && !bvalid_q;
    assign ar_hs = idle && req.arvalid;
    assign wr_hs = idle && !req.arvalid && req.awvalid && req.wvalid;

    // Strobed load replaces the increment for one cycle
    always_comb begin
        if (wr_hs) begin
            mtime_d = mtime_q;
            for (int b = 0; b < strb_w; b++) begin
                if (req.wstrb[b]) begin
                    mtime_d[8*b +: 8] = req.wdata[8*b +: 8];
                end
            end
        end else begin
            mtime_d = mtime_q + 1;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= mtime_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime_q  <= '0;
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            mtime_q <= mtime_d;
            if (ar_hs) begin
                rvalid_q <= 1'b1;
            end else if (req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_comb begin
        resp.arready = idle;
        resp.rdata   = rdata_q;
        resp.rresp   = resp_okay;
        resp.rvalid  = rvalid_q;
        resp.awready = wr_hs;
        resp.wready  = wr_hs;
        resp.bresp   = resp_okay;
        resp.bvalid  = bvalid_q;
    end

endmodule

`default_nettype wire

/* src/axi_lite_console.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_console
    import soc_bus_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire axi_lite_req_t req,
    output axi_lite_resp_t     resp,
    output logic [7:0]         tx_data,
    output logic               tx_valid
);

    logic [7:0]        count_q;
    logic [data_w-1:0] rdata_q;
    logic              rvalid_q;
    logic              bvalid_q;
    logic              idle;
    logic              ar_hs;
    logic              wr_hs;

    assign idle  = !rvalid_q && !bvalid_q;
    assign ar_hs = idle && req.arvalid;
    assign wr_hs = idle && !req.arvalid && req.awvalid && req.wvalid;

    // Byte leaves in the write handshake cycle
    assign tx_data  = req.wdata[7:0];
    assign tx_valid = wr_hs;

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= {{(data_w-8){1'b0}}, count_q};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q  <= 8'd0;
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (wr_hs) begin
                count_q  <= count_q + 8'd1;
                bvalid_q <= 1'b1;
            end else if (req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (ar_hs) begin
                rvalid_q <= 1'b1;
            end else if (req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_comb begin
        resp.arready = idle;
        resp.rdata   = rdata_q;
        resp.rresp   = resp_okay;
        resp.rvalid  = rvalid_q;
        resp.awready = wr_hs;
        resp.wready  = wr_hs;
        resp.bresp   = resp_okay;
        resp.bvalid  = bvalid_q;
    end

endmodule

`default_nettype wire

/* src/axi_lite_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_sram
    import soc_bus_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire axi_lite_req_t req,
    output axi_lite_resp_t     resp
);

    logic [data_w-1:0]     mem [sram_words];
    logic [data_w-1:0]     rdata_q;
    logic                  rvalid_q;
    logic                  bvalid_q;
    logic                  idle;
    logic                  ar_hs;
    logic                  wr_hs;
    logic [sram_idx_w-1:0] rd_idx;
    logic [sram_idx_w-1:0] wr_idx;

    // Upper address bits alias onto the word index
    assign rd_idx = req.araddr[sram_idx_w+1:2];
    assign wr_idx = req.awaddr[sram_idx_w+1:2];

    assign idle  = !rvalid_q && !bvalid_q;
    assign ar_hs = idle && req.arvalid;
    assign wr_hs = idle && !req.arvalid && req.awvalid && req.wvalid;

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            for (int b = 0; b < strb_w; b++) begin
                if (req.wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
        if (ar_hs) begin
            rdata_q <= mem[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (ar_hs) begin
                rvalid_q <= 1'b1;
            end else if (req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_comb begin
        resp.arready = idle;
        resp.rdata   = rdata_q;
        resp.rresp   = resp_okay;
        resp.rvalid  = rvalid_q;
        resp.awready = wr_hs;
        resp.wready  = wr_hs;
        resp.bresp   = resp_okay;
        resp.bvalid  = bvalid_q;
    end

endmodule

`default_nettype wire

/* src/axi_lite_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_xbar
    import soc_bus_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire axi_lite_req_t  bus_req,
    output axi_lite_resp_t      bus_resp,
    output axi_lite_req_t       sram_req,
    output axi_lite_req_t       console_req,
    output axi_lite_req_t       clint_req,
    input  wire axi_lite_resp_t sram_resp,
    input  wire axi_lite_resp_t console_resp,
    input  wire axi_lite_resp_t clint_resp
);

    slave_sel_e sel_q;
    slave_sel_e sel_now;
    slave_sel_e sel;
    logic       active_q;
    logic       offer;
    logic       done;

    function automatic slave_sel_e decode_addr(input logic [addr_w-1:0] addr);
        slave_sel_e target;
        if (addr == uart_thr_addr) begin
            target = sel_console;
        end else if ((addr & clint_mask) == clint_mtime_addr) begin
            target = sel_clint;
        end else begin
            target = sel_sram;
        end
        return target;
    endfunction

    // Read address takes precedence when both are offered
    assign sel_now = decode_addr(bus_req.arvalid ? bus_req.araddr : bus_req.awaddr);
    assign offer   = bus_req.arvalid | bus_req.awvalid;
    assign done    = (bus_req.rready & bus_resp.rvalid) | (bus_req.bready & bus_resp.bvalid);
    assign sel     = active_q ? sel_q : sel_now;

    // Selection is frozen from the first offer until the response handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            active_q <= 1'b0;
            sel_q    <= sel_sram;
        end else if (done) begin
            active_q <= 1'b0;
        end else if (!active_q && offer) begin
            active_q <= 1'b1;
            sel_q    <= sel_now;
        end
    end

    always_comb begin
        sram_req    = '0;
        console_req = '0;
        clint_req   = '0;
        case (sel)
            sel_console: begin
                console_req = bus_req;
                bus_resp    = console_resp;
            end
            sel_clint: begin
                clint_req = bus_req;
                bus_resp  = clint_resp;
            end
            default: begin
                sram_req = bus_req;
                bus_resp = sram_resp;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/axi_lite_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_arbiter
    import soc_bus_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire axi_lite_req_t  m0_req,
    input  wire axi_lite_req_t  m1_req,
    output axi_lite_resp_t      m0_resp,
    output axi_lite_resp_t      m1_resp,
    output axi_lite_req_t       bus_req,
    input  wire axi_lite_resp_t bus_resp
);

    arb_state_e state_q;
    arb_state_e state_d;
    logic       last_m1_q;
    logic       m0_want;
    logic       m1_want;
    logic       done;

    assign m0_want = m0_req.arvalid | m0_req.awvalid;
    assign m1_want = m1_req.arvalid | m1_req.awvalid;

    // Transaction ends on the R or B handshake
    assign done = (bus_req.rready & bus_resp.rvalid) | (bus_req.bready & bus_resp.bvalid);

    always_comb begin
        state_d = state_q;
        case (state_q)
            arb_idle: begin
                // On a tie the master not served last wins
                if (m0_want && (!m1_want || last_m1_q)) begin
                    state_d = arb_busy_m0;
                end else if (m1_want) begin
                    state_d = arb_busy_m1;
                end
            end
            default: begin
                if (done) begin
                    state_d = arb_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= arb_idle;
            last_m1_q <= 1'b1;
        end else begin
            state_q <= state_d;
            if (state_q == arb_idle && state_d != arb_idle) begin
                last_m1_q <= (state_d == arb_busy_m1);
            end
        end
    end

    // Only the granted master is connected
    always_comb begin
        bus_req = '0;
        m0_resp = '0;
        m1_resp = '0;
        case (state_q)
            arb_busy_m0: begin
                bus_req = m0_req;
                m0_resp = bus_resp;
            end
            arb_busy_m1: begin
                bus_req = m1_req;
                m1_resp = bus_resp;
            end
            default: begin
                bus_req = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    // Bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;
    localparam int resp_w = 2;

    // Unmatched addresses land in the SRAM
    localparam logic [addr_w-1:0] uart_thr_addr    = 32'ha000_03f8;
    localparam logic [addr_w-1:0] clint_mtime_addr = 32'ha000_0048;
    localparam logic [addr_w-1:0] clint_mask       = 32'hffff_fffc;

    localparam int sram_words = 1024;
    localparam int sram_idx_w = $clog2(sram_words);

    localparam logic [resp_w-1:0] resp_okay = 2'b00;

    typedef struct packed {
        logic [addr_w-1:0] araddr;
        logic              arvalid;
        logic              rready;
        logic [addr_w-1:0] awaddr;
        logic              awvalid;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
        logic              wvalid;
        logic              bready;
    } axi_lite_req_t;

    typedef struct packed {
        logic              arready;
        logic [data_w-1:0] rdata;
        logic [resp_w-1:0] rresp;
        logic              rvalid;
        logic              awready;
        logic              wready;
        logic [resp_w-1:0] bresp;
        logic              bvalid;
    } axi_lite_resp_t;

    typedef enum logic [1:0] {
        sel_sram,
        sel_console,
        sel_clint
    } slave_sel_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_busy_m0,
        arb_busy_m1
    } arb_state_e;

endpackage

`default_nettype wire
